//--- verilog/serial_pkg.sv
package serial_pkg;

   // one data word as held in the register file and carried by a load
   typedef logic [31:0] word_t;

   // index into the four entry register file
   typedef logic [1:0] reg_addr_t;

   // shift distance taken from the low bits of the second operand
   typedef logic [4:0] shamt_t;

   // load and the single stage ops come first, slt and sll need an init stage
   typedef enum logic [2:0] {
      OP_LOAD = 3'd0,
      OP_ADD  = 3'd1,
      OP_SUB  = 3'd2,
      OP_AND  = 3'd3,
      OP_XOR  = 3'd4,
      OP_SLT  = 3'd5,
      OP_SLL  = 3'd6
   } opcode_t;

   // one command as strobed in by the host
   // imm is only looked at by OP_LOAD, rs1 and rs2 are ignored there
   typedef struct packed {
      opcode_t   op;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      word_t     imm;
   } cmd_t;

endpackage

//--- verilog/serial_state.sv
`timescale 1ns/10ps

module serial_state
   import serial_pkg::*;
   #(parameter bit WITH_SHIFT = 1'b1)
   (
   input  logic    i_clk,
   input  logic    i_rst,
   input  logic    i_start,
   input  opcode_t i_op,
   output logic    o_ready,
   output logic    o_cnt_en,
   output logic    o_init,
   output logic    o_cnt0,
   output logic    o_cnt0to4,
   output logic    o_cnt_done,
   output logic    o_rf_wen,
   output logic    o_result_valid
   );

   // upper three bits of the cycle count, the ring holds the lower two one-hot
   logic [2:0] cnt_word;
   logic [3:0] cnt_ring;
   logic       busy;
   // the command register in the top is loaded on the start edge
   // so the opcode is only valid one cycle later
   logic       start_q;
   // one cycle strobe in the gap between the init and run stage
   logic       stage_two_req;
   logic       two_stage_op;

   // slt needs a full pass to compare before anything is written
   // sll needs a pass to fill the shift buffer, unless the shifter is left out
   assign two_stage_op = (i_op == OP_SLT) | (WITH_SHIFT & (i_op == OP_SLL));

   assign o_ready = !busy;

   // cycle 0 is word count zero with the ring on its first bit
   assign o_cnt0 = (cnt_word == 3'd0) & cnt_ring[0];

   // cycles 0 to 3 are the whole first word, cycle 4 is the first bit of the next
   assign o_cnt0to4 = (cnt_word == 3'd0) | ((cnt_word == 3'd1) & cnt_ring[0]);

   // the destination is only written while running, never during init
   assign o_rf_wen = o_cnt_en & !o_init;

   always_ff @(posedge i_clk) begin
      start_q <= i_start;

      // registered, so this is high during cycle 31 of the stage
      o_cnt_done <= o_cnt_en & (cnt_word == 3'd7) & cnt_ring[2];

      // end of init stage kicks off the run stage after one idle cycle
      stage_two_req <= o_cnt_done & o_init;

      // the last write bit lands together with this strobe going high
      o_result_valid <= o_cnt_done & !o_init;

      if (i_start)
         busy <= 1'b1;
      if (o_cnt_done & !o_init)
         busy <= 1'b0;

      if (start_q)
         o_init <= two_stage_op;
      if (o_cnt_done)
         o_init <= 1'b0;

      if (start_q | stage_two_req)
         o_cnt_en <= 1'b1;
      if (o_cnt_done)
         o_cnt_en <= 1'b0;

      // the ring steps every enabled cycle and carries into the word count
      // after 32 steps both are back at their start values
      if (o_cnt_en) begin
         cnt_word <= cnt_word + {2'd0, cnt_ring[3]};
         cnt_ring <= {cnt_ring[2:0], cnt_ring[3]};
      end

      if (i_rst) begin
         start_q        <= 1'b0;
         o_cnt_done     <= 1'b0;
         stage_two_req  <= 1'b0;
         o_result_valid <= 1'b0;
         busy           <= 1'b0;
         o_init         <= 1'b0;
         o_cnt_en       <= 1'b0;
         cnt_word       <= 3'd0;
         cnt_ring       <= 4'b0001;
      end
   end

endmodule

//--- verilog/serial_regfile.sv
`timescale 1ns/10ps

module serial_regfile
   import serial_pkg::*;
   (
   input  logic      i_clk,
   input  logic      i_rst,
   input  logic      i_cnt_en,
   input  logic      i_wen,
   input  reg_addr_t i_rs1,
   input  reg_addr_t i_rs2,
   input  reg_addr_t i_rd,
   input  logic      i_wbit,
   output logic      o_rs1_bit,
   output logic      o_rs2_bit,
   output word_t     o_rd_word
   );

   word_t regs [4];

   // each source register is rotated so that bit 0 is always the current bit
   assign o_rs1_bit = regs[i_rs1][0];
   assign o_rs2_bit = regs[i_rs2][0];

   // full destination word, aligned again one cycle after the last write bit
   assign o_rd_word = regs[i_rd];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < 4; i++)
            regs[i] <= '0;
      end else if (i_cnt_en) begin
         for (int i = 0; i < 4; i++) begin
            // the write shifts the same way as a read rotate, so when rd is also
            // a source the bit read this cycle is still the old one
            if (i_wen && (i_rd == reg_addr_t'(i))) begin
               regs[i] <= {i_wbit, regs[i][31:1]};
            end else if ((i_rs1 == reg_addr_t'(i)) || (i_rs2 == reg_addr_t'(i))) begin
               // rotate once even when rs1 and rs2 name the same register
               regs[i] <= {regs[i][0], regs[i][31:1]};
            end
         end
      end
   end

endmodule

//--- verilog/serial_alu.sv
`timescale 1ns/10ps

module serial_alu
   import serial_pkg::*;
   (
   input  logic    i_clk,
   input  logic    i_rst,
   input  logic    i_cnt_en,
   input  logic    i_cnt0,
   input  opcode_t i_op,
   input  logic    i_a,
   input  logic    i_b,
   output logic    o_bit,
   output logic    o_lt
   );

   // subtract and compare both run a + ~b + 1
   logic b_inv;
   logic b_eff;
   logic c_in;
   logic sum;
   logic c_out;
   logic carry;
   logic lt_q;
   logic lt_next;

   assign b_inv = (i_op == OP_SUB) | (i_op == OP_SLT);
   assign b_eff = i_b ^ b_inv;

   // on cycle 0 the carry in is the +1 of the two's complement, or zero for add
   assign c_in = i_cnt0 ? b_inv : carry;

   assign sum   = i_a ^ b_eff ^ c_in;
   assign c_out = (i_a & b_eff) | (c_in & (i_a ^ b_eff));

   // signed less-than over the bits seen so far, treating this bit as the sign
   // differing signs decide it directly, equal signs leave it to the borrow
   assign lt_next = (i_a ^ i_b) ? i_a : sum;

   always_comb begin
      case (i_op)
         OP_AND:  o_bit = i_a & i_b;
         OP_XOR:  o_bit = i_a ^ i_b;
         default: o_bit = sum;
      endcase
   end

   // after the 32nd enabled cycle lt_q holds the full signed compare
   // it is read on cycle 0 of the next stage, before it is overwritten
   assign o_lt = lt_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry <= 1'b0;
         lt_q  <= 1'b0;
      end else if (i_cnt_en) begin
         carry <= c_out;
         lt_q  <= lt_next;
      end
   end

endmodule

//--- verilog/serial_bufreg.sv
`timescale 1ns/10ps

module serial_bufreg
   import serial_pkg::*;
   #(parameter bit WITH_SHIFT = 1'b1)
   (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_cnt_en,
   input  logic i_init,
   input  logic i_cnt0to4,
   input  logic i_rs1_bit,
   input  logic i_rs2_bit,
   output logic o_bit
   );

   word_t  data;
   shamt_t shamt;
   logic   shift_done;

   assign shift_done = (shamt == '0);

   // zeros fill the low bits until the shift amount has run out
   // then the buffered rs1 comes out from bit 0 upwards
   assign o_bit = WITH_SHIFT & shift_done & data[0];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         data  <= '0;
         shamt <= '0;
      end else if (i_cnt_en) begin
         if (i_init) begin
            // after 32 init cycles rs1 sits aligned in the buffer
            data <= {i_rs1_bit, data[31:1]};
            // five shifts leave rs2 bits 4 to 0 in place
            if (i_cnt0to4)
               shamt <= {i_rs2_bit, shamt[4:1]};
         end else if (!shift_done) begin
            shamt <= shamt - 1'b1;
         end else begin
            data <= {1'b0, data[31:1]};
         end
      end
   end

endmodule

//--- verilog/serial_exec_top.sv
`timescale 1ns/10ps

module serial_exec_top
   import serial_pkg::*;
   #(parameter bit WITH_SHIFT = 1'b1)
   (
   input  logic      i_clk,
   input  logic      i_rst,
   input  logic      i_cmd_valid,
   input  cmd_t      i_cmd,
   output logic      o_ready,
   output logic      o_result_valid,
   output reg_addr_t o_result_addr,
   output word_t     o_result
   );

   cmd_t cmd_q;
   logic start;
   logic cnt_en;
   logic init;
   logic cnt0;
   logic cnt0to4;
   logic rf_wen;
   logic rs1_bit;
   logic rs2_bit;
   logic alu_bit;
   logic lt_flag;
   logic sh_bit;
   logic wbit;

   // a strobe while busy is simply dropped
   assign start = i_cmd_valid & o_ready;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cmd_q <= '0;
      end else if (start) begin
         cmd_q <= i_cmd;
      end else if (rf_wen) begin
         // the constant is walked down so bit 0 is the bit for this cycle
         cmd_q.imm <= {1'b0, cmd_q.imm[31:1]};
      end
   end

   // write source for the destination register
   always_comb begin
      case (cmd_q.op)
         OP_LOAD: wbit = cmd_q.imm[0];
         // result is 0 or 1, so only the first bit can be set
         OP_SLT:  wbit = cnt0 & lt_flag;
         OP_SLL:  wbit = sh_bit;
         default: wbit = alu_bit;
      endcase
   end

   assign o_result_addr = cmd_q.rd;

   serial_state #(
      .WITH_SHIFT (WITH_SHIFT)
   ) u_state (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_start        (start),
      .i_op           (cmd_q.op),
      .o_ready        (o_ready),
      .o_cnt_en       (cnt_en),
      .o_init         (init),
      .o_cnt0         (cnt0),
      .o_cnt0to4      (cnt0to4),
      .o_cnt_done     (),
      .o_rf_wen       (rf_wen),
      .o_result_valid (o_result_valid)
   );

   serial_regfile u_regfile (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_cnt_en  (cnt_en),
      .i_wen     (rf_wen),
      .i_rs1     (cmd_q.rs1),
      .i_rs2     (cmd_q.rs2),
      .i_rd      (cmd_q.rd),
      .i_wbit    (wbit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit),
      .o_rd_word (o_result)
   );

   serial_alu u_alu (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_cnt_en (cnt_en),
      .i_cnt0   (cnt0),
      .i_op     (cmd_q.op),
      .i_a      (rs1_bit),
      .i_b      (rs2_bit),
      .o_bit    (alu_bit),
      .o_lt     (lt_flag)
   );

   serial_bufreg #(
      .WITH_SHIFT (WITH_SHIFT)
   ) u_bufreg (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_cnt_en  (cnt_en),
      .i_init    (init),
      .i_cnt0to4 (cnt0to4),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .o_bit     (sh_bit)
   );

endmodule

//--- bench/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen
   #(parameter int HALF_PERIOD  = 50,
     parameter int RESET_CYCLES = 10)
   (
   output logic o_clk,
   output logic o_rst
   );

   // free running clock, 100 ns period with the default half period
   initial begin
      o_clk = 1'b0;
      forever #(HALF_PERIOD) o_clk = ~o_clk;
   end

   // reset is dropped on a falling edge so the DUT sees a clean release
   initial begin
      o_rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_rst = 1'b0;
   end

endmodule

//--- bench/tb_serial_exec.sv
`timescale 1ns/10ps

module tb_serial_exec
   import serial_pkg::*;
   ();

   localparam bit SHIFT_ON = 1'b1;
   // number of the cycle that shows the result strobe when the cycle after the accepting
   // edge is cycle 1
   localparam int ONE_STAGE_LAT = 34;
   localparam int TWO_STAGE_LAT = 67;
   // no command takes longer than this, not even a two stage op
   localparam int CYCLES_PER_CMD = 70;
   // about 80 commands are issued in all and the reset and the drop window come on top
   localparam int MAX_CMDS    = 90;
   localparam int CYCLE_LIMIT = 10 + MAX_CMDS * CYCLES_PER_CMD + 300;

   logic      clk;
   logic      rst;
   logic      cmd_valid;
   cmd_t      cmd;
   logic      ready;
   logic      result_valid;
   reg_addr_t result_addr;
   word_t     result;

   // expected register contents as every command leaves them
   word_t  model_regs [4];
   integer seed = 32'h88a9;
   int     error_count = 0;
   int     check_count = 0;
   int     test_count = 0;
   int     cycle_count = 0;

   tb_clkgen #(
      .HALF_PERIOD  (50),
      .RESET_CYCLES (10)
   ) u_clkgen (
      .o_clk (clk),
      .o_rst (rst)
   );

   serial_exec_top #(
      .WITH_SHIFT (SHIFT_ON)
   ) u_dut (
      .i_clk          (clk),
      .i_rst          (rst),
      .i_cmd_valid    (cmd_valid),
      .i_cmd          (cmd),
      .o_ready        (ready),
      .o_result_valid (result_valid),
      .o_result_addr  (result_addr),
      .o_result       (result)
   );

   function automatic word_t next_random();
      return word_t'($random(seed));
   endfunction

   // value the destination should hold after one command
   function automatic word_t model_result(opcode_t op, word_t a, word_t b, word_t imm);
      case (op)
         OP_LOAD: return imm;
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_XOR:  return a ^ b;
         OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         // only the low five bits of the second operand count
         OP_SLL:  return SHIFT_ON ? (a << b[4:0]) : 32'd0;
         default: return 32'd0;
      endcase
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic report_test(input string name, input int start_err);
      test_count++;
      if (error_count == start_err)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, error_count - start_err);
   endtask

   // strobe one command on a falling edge and wait for its result strobe
   // returns at the falling edge where the result is visible
   // lat ends as the number of that cycle, counted from 1 after the accepting edge
   task automatic issue_cmd(input cmd_t c, output int lat, output logic got);
      lat = 1;
      cmd = c;
      cmd_valid = 1'b1;
      @(negedge clk);
      cmd_valid = 1'b0;
      while (!result_valid && lat < CYCLES_PER_CMD) begin
         @(negedge clk);
         lat++;
      end
      got = result_valid;
   endtask

   // run one command and check address, data, latency and the ready flag
   task automatic exec_cmd(input opcode_t op, input reg_addr_t rd, input reg_addr_t rs1,
                           input reg_addr_t rs2, input word_t imm);
      cmd_t  c;
      word_t exp;
      int    lat;
      int    exp_lat;
      logic  got;
      c = '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm};
      exp = model_result(op, model_regs[rs1], model_regs[rs2], imm);
      exp_lat = ((op == OP_SLT) || (SHIFT_ON && op == OP_SLL)) ? TWO_STAGE_LAT : ONE_STAGE_LAT;
      issue_cmd(c, lat, got);
      if (!got) begin
         error_count++;
         $display("%s gave no result strobe within %0d cycles", op.name(), CYCLES_PER_CMD);
      end else begin
         if (lat != exp_lat) begin
            error_count++;
            $display("%s finished after %0d cycles instead of %0d", op.name(), lat, exp_lat);
         end
         check_addr("o_result_addr", result_addr, rd);
         check_word("o_result", result, exp);
         // the unit is idle again in the same cycle as the result
         check_flag("o_ready", ready, 1'b1);
      end
      model_regs[rd] = exp;
   endtask

   // load both operands into r2 and r3 and then write the op result to r1
   task automatic op_case(input opcode_t op, input word_t a, input word_t b);
      exec_cmd(OP_LOAD, 2'd2, 2'd0, 2'd0, a);
      exec_cmd(OP_LOAD, 2'd3, 2'd0, 2'd0, b);
      exec_cmd(op, 2'd1, 2'd2, 2'd3, 32'd0);
   endtask

   task automatic test_reset_state();
      int start_err;
      start_err = error_count;
      check_flag("o_ready", ready, 1'b1);
      repeat (5) begin
         check_flag("o_result_valid", result_valid, 1'b0);
         @(negedge clk);
      end
      report_test("reset state", start_err);
   endtask

   task automatic test_load_all();
      int start_err;
      start_err = error_count;
      for (int r = 0; r < 4; r++)
         exec_cmd(OP_LOAD, reg_addr_t'(r), 2'd0, 2'd0, next_random());
      report_test("load", start_err);
   endtask

   // one fixed corner case followed by two random operand pairs
   task automatic test_single_stage(input opcode_t op, input word_t a, input word_t b);
      int start_err;
      start_err = error_count;
      op_case(op, a, b);
      op_case(op, next_random(), next_random());
      op_case(op, next_random(), next_random());
      report_test(op.name(), start_err);
   endtask

   task automatic test_rd_is_rs1();
      int start_err;
      start_err = error_count;
      exec_cmd(OP_LOAD, 2'd0, 2'd0, 2'd0, next_random());
      exec_cmd(OP_LOAD, 2'd1, 2'd0, 2'd0, next_random());
      exec_cmd(OP_ADD, 2'd0, 2'd0, 2'd1, 32'd0);
      exec_cmd(OP_SUB, 2'd1, 2'd1, 2'd0, 32'd0);
      // and with itself reads a register back without changing it
      exec_cmd(OP_AND, 2'd0, 2'd0, 2'd0, 32'd0);
      report_test("rd equals rs1", start_err);
   endtask

   task automatic test_slt();
      int    start_err;
      word_t x;
      start_err = error_count;
      op_case(OP_SLT, 32'hffff_fff0, 32'h0000_0005);
      op_case(OP_SLT, 32'h0000_0005, 32'hffff_fff0);
      op_case(OP_SLT, 32'h8000_0000, 32'h7fff_ffff);
      x = next_random();
      op_case(OP_SLT, x, x);
      op_case(OP_SLT, next_random(), next_random());
      report_test("slt", start_err);
   endtask

   task automatic test_sll();
      int     start_err;
      word_t  r;
      shamt_t amounts [5];
      start_err = error_count;
      amounts = '{5'd0, 5'd1, 5'd31, 5'd0, 5'd0};
      amounts[3] = shamt_t'(next_random());
      amounts[4] = shamt_t'(next_random());
      for (int i = 0; i < 5; i++) begin
         // upper bits of the amount operand are noise and must be ignored
         r = next_random();
         op_case(OP_SLL, next_random(), {r[31:5], amounts[i]});
      end
      report_test("sll", start_err);
   endtask

   task automatic test_dropped_strobe();
      int    start_err;
      int    pulses;
      word_t exp;
      cmd_t  good_cmd;
      cmd_t  bad_cmd;
      start_err = error_count;
      exec_cmd(OP_LOAD, 2'd1, 2'd0, 2'd0, next_random());
      exec_cmd(OP_LOAD, 2'd2, 2'd0, 2'd0, next_random());
      exp = model_regs[1] + model_regs[2];
      good_cmd = '{op: OP_ADD, rd: 2'd0, rs1: 2'd1, rs2: 2'd2, imm: 32'd0};
      bad_cmd = '{op: OP_LOAD, rd: 2'd1, rs1: 2'd0, rs2: 2'd0, imm: ~model_regs[1]};
      cmd = good_cmd;
      cmd_valid = 1'b1;
      @(negedge clk);
      cmd_valid = 1'b0;
      repeat (5) @(negedge clk);
      check_flag("o_ready", ready, 1'b0);
      // this load arrives while busy and has to vanish
      cmd = bad_cmd;
      cmd_valid = 1'b1;
      @(negedge clk);
      cmd_valid = 1'b0;
      pulses = 0;
      repeat (2 * CYCLES_PER_CMD) begin
         if (result_valid) begin
            pulses++;
            check_addr("o_result_addr", result_addr, 2'd0);
            check_word("o_result", result, exp);
         end
         @(negedge clk);
      end
      if (pulses != 1) begin
         error_count++;
         $display("dropped strobe case saw %0d result strobes instead of one", pulses);
      end
      model_regs[0] = exp;
      // r1 still has to hold the value loaded before the dropped strobe
      exec_cmd(OP_AND, 2'd1, 2'd1, 2'd1, 32'd0);
      report_test("dropped strobe", start_err);
   endtask

   // stops a hung run once the whole test sequence should have finished
   initial begin
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("run stopped after %0d cycles before the tests finished", cycle_count);
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin
      cmd_valid = 1'b0;
      cmd = '0;
      // the register file comes out of reset cleared
      for (int r = 0; r < 4; r++)
         model_regs[r] = 32'd0;
      @(negedge clk);
      wait (!rst);
      @(negedge clk);

      test_reset_state();
      test_load_all();
      test_single_stage(OP_ADD, 32'hffff_ffff, 32'h0000_0001);
      test_single_stage(OP_SUB, 32'h0000_0003, 32'h0000_0007);
      test_single_stage(OP_AND, 32'hf0f0_f0f0, 32'hff00_ff00);
      test_single_stage(OP_XOR, 32'haaaa_5555, 32'hffff_0000);
      test_rd_is_rs1();
      test_slt();
      test_sll();
      test_dropped_strobe();

      $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- flist.f
verilog/serial_pkg.sv
verilog/serial_state.sv
verilog/serial_regfile.sv
verilog/serial_alu.sv
verilog/serial_bufreg.sv
verilog/serial_exec_top.sv
bench/tb_clkgen.sv
bench/tb_serial_exec.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_serial_exec
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
